//--- src/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

    // number of joint entries, each covering an even/odd page pair
    localparam int TLB_NUM   = 16;
    localparam int TLB_IDX_W = 4;

    // tag field widths
    localparam int VPN2_W = 19;
    localparam int ASID_W = 8;

    // physical frame and cache attribute widths
    localparam int PFN_W = 20;
    localparam int C_W   = 3;

    typedef logic [TLB_IDX_W-1:0] tlb_index_t;

    // top index, where Random restarts
    localparam tlb_index_t TLB_TOP_INDEX = tlb_index_t'(TLB_NUM - 1);

    // one stored entry, 78 bits
    // tag part first, then even page, then odd page
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        // global page, asid ignored on compare
        logic              g;
        // even page half
        logic [PFN_W-1:0]  pfn0;
        logic [C_W-1:0]    c0;
        logic              d0;
        logic              v0;
        // odd page half
        logic [PFN_W-1:0]  pfn1;
        logic [C_W-1:0]    c1;
        logic              d1;
        logic              v1;
    } tlb_entry_t;

    // lookup answer for one port, 30 bits
    typedef struct packed {
        // any entry hit
        logic             found;
        // lowest hitting entry, zero on a miss
        tlb_index_t       index;
        // page half picked by odd_page
        logic [PFN_W-1:0] pfn;
        logic [C_W-1:0]   c;
        logic             d;
        logic             v;
    } tlb_search_t;

endpackage

`default_nettype wire

//--- src/tlb_write_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_write_ctrl (
    input  wire logic                       clk,
    input  wire logic                       resetn,

    // write strobe from TLBWI / TLBWR
    input  wire logic                       i_we,
    input  wire logic                       i_w_random,
    input  wire tlb_pkg::tlb_index_t        i_w_index,
    input  wire tlb_pkg::tlb_entry_t        i_w_entry,

    // Wired register write
    input  wire logic                       i_wired_we,
    input  wire tlb_pkg::tlb_index_t        i_wired,

    output logic [tlb_pkg::TLB_NUM-1:0]     o_slot_we,
    output tlb_pkg::tlb_entry_t             o_w_entry,
    output tlb_pkg::tlb_index_t             o_random
);

    import tlb_pkg::*;

    // lower bound of the random range
    tlb_index_t wired_q;
    // free-running replacement pointer
    tlb_index_t random_q;
    // slot picked for this cycle's write
    tlb_index_t w_target;

    // Wired and Random registers
    always_ff @(posedge clk) begin
        if (resetn) begin
            wired_q  <= '0;
            random_q <= TLB_TOP_INDEX;
        end else if (i_wired_we) begin
            // new boundary, restart the count from the top
            wired_q  <= i_wired;
            random_q <= TLB_TOP_INDEX;
        end else if (random_q <= wired_q) begin
            // reached the boundary, wrap back to 15
            // wired of 15 keeps random parked at 15
            random_q <= TLB_TOP_INDEX;
        end else begin
            random_q <= random_q - 1'b1;
        end
    end

    // TLBWR takes Random, TLBWI takes the given index
    assign w_target = i_w_random ? random_q : i_w_index;

    // one-hot strobe, one bit per slot
    always_comb begin
        o_slot_we = '0;
        if (i_we) begin
            o_slot_we[w_target] = 1'b1;
        end
    end

    // same write data fans out to every slot
    assign o_w_entry = i_w_entry;

    // architectural Random value
    assign o_random = random_q;

endmodule

`default_nettype wire

//--- src/tlb_slot.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_slot (
    input  wire logic                       clk,
    input  wire logic                       resetn,

    // this slot's own strobe and shared write data
    input  wire logic                       i_we,
    input  wire tlb_pkg::tlb_entry_t        i_w_entry,

    // instruction lookup tag
    input  wire logic [tlb_pkg::VPN2_W-1:0] i_i_vpn2,
    input  wire logic [tlb_pkg::ASID_W-1:0] i_i_asid,

    // data lookup tag
    input  wire logic [tlb_pkg::VPN2_W-1:0] i_d_vpn2,
    input  wire logic [tlb_pkg::ASID_W-1:0] i_d_asid,

    output tlb_pkg::tlb_entry_t             o_entry,
    output logic                            o_i_match,
    output logic                            o_d_match
);

    import tlb_pkg::*;

    // stored entry
    tlb_entry_t entry_q;

    // per-port tag compare terms
    logic i_vpn_eq;
    logic i_asid_ok;
    logic d_vpn_eq;
    logic d_asid_ok;

    // cleared on reset, loaded on strobe
    // new contents show up the cycle after the edge
    always_ff @(posedge clk) begin
        if (resetn) begin
            entry_q <= '0;
        end else if (i_we) begin
            entry_q <= i_w_entry;
        end
    end

    // instruction port compare
    assign i_vpn_eq  = (i_i_vpn2 == entry_q.vpn2);
    // global pages hit under any asid
    assign i_asid_ok = (i_i_asid == entry_q.asid) || entry_q.g;
    assign o_i_match = i_vpn_eq && i_asid_ok;

    // data port compare, same rule
    assign d_vpn_eq  = (i_d_vpn2 == entry_q.vpn2);
    assign d_asid_ok = (i_d_asid == entry_q.asid) || entry_q.g;
    assign o_d_match = d_vpn_eq && d_asid_ok;

    // stored entry out to lookup and read mux
    assign o_entry = entry_q;

endmodule

`default_nettype wire

//--- src/tlb_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup (
    // all stored entries, index 0 in the low slice
    input  wire tlb_pkg::tlb_entry_t [tlb_pkg::TLB_NUM-1:0] i_entries,

    // per-slot hit vectors
    input  wire logic [tlb_pkg::TLB_NUM-1:0]               i_i_match,
    input  wire logic [tlb_pkg::TLB_NUM-1:0]               i_d_match,

    // page half select per port
    input  wire logic                                      i_i_odd_page,
    input  wire logic                                      i_d_odd_page,

    // TLBR index
    input  wire tlb_pkg::tlb_index_t                       i_r_index,

    output tlb_pkg::tlb_search_t                           o_i_result,
    output tlb_pkg::tlb_search_t                           o_d_result,
    output tlb_pkg::tlb_entry_t                            o_r_entry
);

    import tlb_pkg::*;

    // lowest set bit of a hit vector
    // zero when nothing hits
    function automatic tlb_index_t lowest_index(
        input logic [TLB_NUM-1:0] match
    );
        tlb_index_t idx;
        idx = '0;
        // walk downward so the lowest hit is written last
        for (int k = TLB_NUM - 1; k >= 0; k--) begin
            if (match[k]) begin
                idx = tlb_index_t'(k);
            end
        end
        return idx;
    endfunction

    // build a search answer from the chosen entry
    function automatic tlb_search_t form_result(
        input logic       found,
        input tlb_index_t idx,
        input tlb_entry_t sel,
        input logic       odd
    );
        tlb_search_t res;
        res.found = found;
        res.index = idx;
        if (odd) begin
            // odd page of the pair
            res.pfn = sel.pfn1;
            res.c   = sel.c1;
            res.d   = sel.d1;
            res.v   = sel.v1;
        end else begin
            // even page of the pair
            res.pfn = sel.pfn0;
            res.c   = sel.c0;
            res.d   = sel.d0;
            res.v   = sel.v0;
        end
        return res;
    endfunction

    // instruction port state
    logic       i_found;
    tlb_index_t i_index;
    tlb_entry_t i_sel;

    // data port state
    logic       d_found;
    tlb_index_t d_index;
    tlb_entry_t d_sel;

    // hit if any slot matched
    assign i_found = |i_i_match;
    assign d_found = |i_d_match;

    // lowest index wins on multiple hits
    assign i_index = lowest_index(i_i_match);
    assign d_index = lowest_index(i_d_match);

    // a miss leaves index 0, so entry 0 feeds the fields
    assign i_sel = i_entries[i_index];
    assign d_sel = i_entries[d_index];

    // even/odd half selection per port
    assign o_i_result = form_result(i_found, i_index, i_sel, i_i_odd_page);
    assign o_d_result = form_result(d_found, d_index, d_sel, i_d_odd_page);

    // TLBR read mux
    assign o_r_entry = i_entries[i_r_index];

endmodule

`default_nettype wire

//--- src/tlb.sv
`timescale 1ns/1ps
`default_nettype none

module tlb (
    input  wire logic                       clk,
    input  wire logic                       resetn,

    // instruction fetch lookup
    input  wire logic [tlb_pkg::VPN2_W-1:0] i_i_vpn2,
    input  wire logic                       i_i_odd_page,
    input  wire logic [tlb_pkg::ASID_W-1:0] i_i_asid,
    output tlb_pkg::tlb_search_t            o_i_result,

    // data lookup
    input  wire logic [tlb_pkg::VPN2_W-1:0] i_d_vpn2,
    input  wire logic                       i_d_odd_page,
    input  wire logic [tlb_pkg::ASID_W-1:0] i_d_asid,
    output tlb_pkg::tlb_search_t            o_d_result,

    // TLBR
    input  wire tlb_pkg::tlb_index_t        i_r_index,
    output tlb_pkg::tlb_entry_t             o_r_entry,

    // TLBWI / TLBWR
    input  wire logic                       i_we,
    input  wire logic                       i_w_random,
    input  wire tlb_pkg::tlb_index_t        i_w_index,
    input  wire tlb_pkg::tlb_entry_t        i_w_entry,

    // Wired register
    input  wire logic                       i_wired_we,
    input  wire tlb_pkg::tlb_index_t        i_wired,

    // current Random register
    output tlb_pkg::tlb_index_t             o_random
);

    import tlb_pkg::*;

    // one-hot write strobe and shared write data
    logic [TLB_NUM-1:0]        slot_we;
    tlb_entry_t                w_entry;

    // stored entries and per-port hit vectors
    tlb_entry_t [TLB_NUM-1:0]  entries;
    logic [TLB_NUM-1:0]        i_match;
    logic [TLB_NUM-1:0]        d_match;

    // Wired/Random and write decode
    tlb_write_ctrl u_write_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .i_we       (i_we),
        .i_w_random (i_w_random),
        .i_w_index  (i_w_index),
        .i_w_entry  (i_w_entry),
        .i_wired_we (i_wired_we),
        .i_wired    (i_wired),
        .o_slot_we  (slot_we),
        .o_w_entry  (w_entry),
        .o_random   (o_random)
    );

    // storage plus comparators, one per entry
    for (genvar n = 0; n < TLB_NUM; n++) begin : g_slot
        tlb_slot u_slot (
            .clk       (clk),
            .resetn    (resetn),
            .i_we      (slot_we[n]),
            .i_w_entry (w_entry),
            .i_i_vpn2  (i_i_vpn2),
            .i_i_asid  (i_i_asid),
            .i_d_vpn2  (i_d_vpn2),
            .i_d_asid  (i_d_asid),
            .o_entry   (entries[n]),
            .o_i_match (i_match[n]),
            .o_d_match (d_match[n])
        );
    end

    // priority encode, page half select, read mux
    tlb_lookup u_lookup (
        .i_entries    (entries),
        .i_i_match    (i_match),
        .i_d_match    (d_match),
        .i_i_odd_page (i_i_odd_page),
        .i_d_odd_page (i_d_odd_page),
        .i_r_index    (i_r_index),
        .o_i_result   (o_i_result),
        .o_d_result   (o_d_result),
        .o_r_entry    (o_r_entry)
    );

endmodule

`default_nettype wire

//--- tests/tlb_tb_vectors.svh
`ifndef TLB_TB_VECTORS_SVH
`define TLB_TB_VECTORS_SVH

// columns: kind, idx, entry vpn2, entry asid, entry g,
//   i vpn2, i odd, i asid, d vpn2, d odd, d asid, i found, i idx, d found, d idx
// idx is the write index, read index or Wired value, by kind

localparam int ROW_COUNT = 48;

localparam row_t ROWS [ROW_COUNT] = '{
    // reset state, all 16 entries read back as zero
    '{OP_RD,     0, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,     1, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,     2, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,     3, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,     4, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,     5, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,     6, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,     7, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,     8, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,     9, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,    10, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,    11, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,    12, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,    13, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,    14, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,    15, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    // nonzero tags miss on both ports
    '{OP_LK,     0, 'h0,   'h0,  0, 'h1234, 0, 'h00, 'h0abc, 1, 'h01, 0, 0,  0, 0},
    // indexed writes, read back on the next cycle
    '{OP_WR,     3, 'h100, 'h11, 0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,     3, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_WR,     5, 'h200, 'h22, 1, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_WR,     9, 'h100, 'h11, 0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,     5, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,     9, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    // 3 and 9 share a tag, global entry 5 hits any asid
    '{OP_LK,     0, 'h0,   'h0,  0, 'h100,  0, 'h11, 'h200,  1, 'h33, 1, 3,  1, 5},
    '{OP_LK,     0, 'h0,   'h0,  0, 'h100,  1, 'h12, 'h200,  0, 'h22, 0, 0,  1, 5},
    '{OP_WR,     1, 'h300, 'h44, 0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_LK,     0, 'h0,   'h0,  0, 'h300,  1, 'h44, 'h100,  1, 'h11, 1, 1,  1, 3},
    // random write with Wired 0, Random is 4 here
    '{OP_RWR,    0, 'h400, 'h55, 0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RRD,    0, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_LK,     0, 'h0,   'h0,  0, 'h400,  0, 'h55, 'h400,  1, 'h56, 1, 4,  0, 0},
    // Wired 12, Random then cycles 15 down to 12
    '{OP_WIRED, 12, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RWR,    0, 'h501, 'h66, 0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RWR,    0, 'h502, 'h66, 0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RWR,    0, 'h503, 'h66, 0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RWR,    0, 'h504, 'h66, 0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RWR,    0, 'h505, 'h66, 0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RWR,    0, 'h506, 'h66, 0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,    12, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,    13, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,    14, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,    15, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RD,    11, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_LK,     0, 'h0,   'h0,  0, 'h505,  1, 'h66, 'h504,  0, 'h66, 1, 15, 1, 12},
    '{OP_LK,     0, 'h0,   'h0,  0, 'h501,  0, 'h66, 'h506,  0, 'h66, 0, 0,  1, 14},
    // Wired 15 parks Random at the top
    '{OP_WIRED, 15, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_RWR,    0, 'h507, 'h66, 0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0},
    '{OP_LK,     0, 'h0,   'h0,  0, 'h507,  1, 'h66, 'h505,  0, 'h66, 1, 15, 0, 0},
    '{OP_RRD,    0, 'h0,   'h0,  0, 'h0,    0, 'h0,  'h0,    0, 'h0,  0, 0,  0, 0}
};

`endif

//--- tests/tlb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_tb;

    import tlb_pkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 4;
    localparam int MARGIN_CYCLES = 20;

    // row kinds
    localparam logic [2:0] OP_RD    = 3'd0;
    localparam logic [2:0] OP_WR    = 3'd1;
    localparam logic [2:0] OP_RWR   = 3'd2;
    localparam logic [2:0] OP_WIRED = 3'd3;
    localparam logic [2:0] OP_LK    = 3'd4;
    // read at the index the last random write used
    localparam logic [2:0] OP_RRD   = 3'd5;

    typedef struct packed {
        logic [2:0]        kind;
        tlb_index_t        idx;
        logic [VPN2_W-1:0] e_vpn2;
        logic [ASID_W-1:0] e_asid;
        logic              e_g;
        logic [VPN2_W-1:0] i_vpn2;
        logic              i_odd;
        logic [ASID_W-1:0] i_asid;
        logic [VPN2_W-1:0] d_vpn2;
        logic              d_odd;
        logic [ASID_W-1:0] d_asid;
        logic              i_found;
        tlb_index_t        i_idx;
        logic              d_found;
        tlb_index_t        d_idx;
    } row_t;

    `include "tlb_tb_vectors.svh"

    logic              clk = 1'b0;
    logic              resetn;
    logic [VPN2_W-1:0] i_i_vpn2;
    logic              i_i_odd_page;
    logic [ASID_W-1:0] i_i_asid;
    logic [VPN2_W-1:0] i_d_vpn2;
    logic              i_d_odd_page;
    logic [ASID_W-1:0] i_d_asid;
    tlb_index_t        i_r_index;
    logic              i_we;
    logic              i_w_random;
    tlb_index_t        i_w_index;
    tlb_entry_t        i_w_entry;
    logic              i_wired_we;
    tlb_index_t        i_wired;
    tlb_search_t       o_i_result;
    tlb_search_t       o_d_result;
    tlb_entry_t        o_r_entry;
    tlb_index_t        o_random;

    // reference state
    tlb_entry_t shadow [TLB_NUM];
    tlb_index_t exp_random;
    tlb_index_t exp_wired;
    tlb_index_t last_rand_idx;

    tlb dut0 (
        .clk          (clk),
        .resetn       (resetn),
        .i_i_vpn2     (i_i_vpn2),
        .i_i_odd_page (i_i_odd_page),
        .i_i_asid     (i_i_asid),
        .o_i_result   (o_i_result),
        .i_d_vpn2     (i_d_vpn2),
        .i_d_odd_page (i_d_odd_page),
        .i_d_asid     (i_d_asid),
        .o_d_result   (o_d_result),
        .i_r_index    (i_r_index),
        .o_r_entry    (o_r_entry),
        .i_we         (i_we),
        .i_w_random   (i_w_random),
        .i_w_index    (i_w_index),
        .i_w_entry    (i_w_entry),
        .i_wired_we   (i_wired_we),
        .i_wired      (i_wired),
        .o_random     (o_random)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_index(input string what, input tlb_index_t got, input tlb_index_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_entry(input string what, input tlb_entry_t got, input tlb_entry_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s entry got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_search(input string what, input tlb_search_t got,
                                input tlb_search_t exp);
        string got_s;
        string exp_s;
        if (got !== exp) begin
            got_s = $sformatf("%b/%0d/%h/%0d/%b/%b",
                              got.found, got.index, got.pfn, got.c, got.d, got.v);
            exp_s = $sformatf("%b/%0d/%h/%0d/%b/%b",
                              exp.found, exp.index, exp.pfn, exp.c, exp.d, exp.v);
            $display("MISMATCH at %0t: %s found/index/pfn/c/d/v got %s expected %s",
                     $time, what, got_s, exp_s);
            abort_run();
        end
    endtask

    // tag fixed by the row and page halves random
    function automatic tlb_entry_t random_entry(input logic [VPN2_W-1:0] vpn2,
                                                input logic [ASID_W-1:0] asid, input logic g);
        tlb_entry_t e;
        e.vpn2 = vpn2;
        e.asid = asid;
        e.g    = g;
        e.pfn0 = PFN_W'($urandom());
        e.c0   = C_W'($urandom());
        e.d0   = 1'($urandom());
        e.v0   = 1'($urandom());
        e.pfn1 = PFN_W'($urandom());
        e.c1   = C_W'($urandom());
        e.d1   = 1'($urandom());
        e.v1   = 1'($urandom());
        return e;
    endfunction

    // a miss reports entry 0's fields
    function automatic tlb_search_t expected_search(input logic found, input tlb_index_t idx,
                                                    input logic odd);
        tlb_entry_t  e;
        tlb_search_t s;
        e       = shadow[found ? idx : tlb_index_t'(0)];
        s.found = found;
        s.index = found ? idx : tlb_index_t'(0);
        s.pfn   = odd ? e.pfn1 : e.pfn0;
        s.c     = odd ? e.c1 : e.c0;
        s.d     = odd ? e.d1 : e.d0;
        s.v     = odd ? e.v1 : e.v0;
        return s;
    endfunction

    task automatic drive_row(input row_t rw, input tlb_entry_t e);
        i_we         <= (rw.kind == OP_WR) || (rw.kind == OP_RWR);
        i_w_random   <= (rw.kind == OP_RWR);
        i_w_index    <= rw.idx;
        i_w_entry    <= e;
        i_wired_we   <= (rw.kind == OP_WIRED);
        i_wired      <= rw.idx;
        i_r_index    <= (rw.kind == OP_RRD) ? last_rand_idx : rw.idx;
        i_i_vpn2     <= rw.i_vpn2;
        i_i_odd_page <= rw.i_odd;
        i_i_asid     <= rw.i_asid;
        i_d_vpn2     <= rw.d_vpn2;
        i_d_odd_page <= rw.d_odd;
        i_d_asid     <= rw.d_asid;
    endtask

    // state as it will be after the next rising edge
    task automatic update_model(input row_t rw, input tlb_entry_t e);
        if (rw.kind == OP_WR) begin
            shadow[rw.idx] = e;
        end else if (rw.kind == OP_RWR) begin
            shadow[exp_random] = e;
            last_rand_idx = exp_random;
        end
        if (rw.kind == OP_WIRED) begin
            exp_wired  = rw.idx;
            exp_random = tlb_index_t'(TLB_NUM - 1);
        end else if (exp_random == exp_wired || exp_wired >= tlb_index_t'(TLB_NUM - 1)) begin
            exp_random = tlb_index_t'(TLB_NUM - 1);
        end else begin
            exp_random = exp_random - 1'b1;
        end
    endtask

    // watchdog sized from the table length
    initial begin
        #(CLK_PERIOD * (ROW_COUNT + RESET_CYCLES + MARGIN_CYCLES));
        $display("ERROR: simulation timed out before all table rows were applied");
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

    initial begin
        row_t       row;
        tlb_entry_t cur_entry;
        void'($urandom(83));
        resetn        = 1'b1;
        i_i_vpn2      = '0;
        i_i_odd_page  = 1'b0;
        i_i_asid      = '0;
        i_d_vpn2      = '0;
        i_d_odd_page  = 1'b0;
        i_d_asid      = '0;
        i_r_index     = '0;
        i_we          = 1'b0;
        i_w_random    = 1'b0;
        i_w_index     = '0;
        i_w_entry     = '0;
        i_wired_we    = 1'b0;
        i_wired       = '0;
        for (int k = 0; k < TLB_NUM; k++) begin
            shadow[k] = '0;
        end
        exp_random    = tlb_index_t'(TLB_NUM - 1);
        exp_wired     = '0;
        last_rand_idx = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        // first row goes out on the edge that releases reset
        resetn <= 1'b0;
        for (int r = 0; r < ROW_COUNT; r++) begin
            row = ROWS[r];
            cur_entry = '0;
            if (row.kind == OP_WR || row.kind == OP_RWR) begin
                cur_entry = random_entry(row.e_vpn2, row.e_asid, row.e_g);
            end
            drive_row(row, cur_entry);
            // combinational outputs settled by mid cycle
            @(negedge clk);
            check_index($sformatf("row %0d o_random", r), o_random, exp_random);
            case (row.kind)
                OP_RD: begin
                    check_entry($sformatf("row %0d read", r), o_r_entry, shadow[row.idx]);
                end
                OP_RRD: begin
                    check_entry($sformatf("row %0d random read", r), o_r_entry,
                                shadow[last_rand_idx]);
                end
                OP_LK: begin
                    check_search($sformatf("row %0d i lookup", r), o_i_result,
                                 expected_search(row.i_found, row.i_idx, row.i_odd));
                    check_search($sformatf("row %0d d lookup", r), o_d_result,
                                 expected_search(row.d_found, row.d_idx, row.d_odd));
                end
                default: begin
                end
            endcase
            update_model(row, cur_entry);
            @(posedge clk);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tlb.f
+incdir+tests
src/tlb_pkg.sv
src/tlb_write_ctrl.sv
src/tlb_slot.sv
src/tlb_lookup.sv
src/tlb.sv
tests/tlb_tb.sv

//--- Bender.yml
package:
  name: tlb

sources:
  # package first, then leaf modules, then the top level
  - src/tlb_pkg.sv
  - src/tlb_write_ctrl.sv
  - src/tlb_slot.sv
  - src/tlb_lookup.sv
  - src/tlb.sv

  # testbench with its vector table header
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tlb_tb.sv
